//--- hw/memfy_pkg.sv
//////////////////////////////////////////////////
// Load/store unit shared definitions
// Widths, RV32 encodings and control state
//////////////////////////////////////////////////

package memfy_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Data and address width
    localparam int xlen       = 32;
    // One strobe per byte lane
    localparam int strb_w     = 4;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 12;
    // Byte offset inside a word
    localparam int off_w      = 2;
    localparam int funct3_w   = 3;
    localparam int opc_w      = 7;

    // Vector types
    typedef logic [xlen-1:0]       word_t;
    typedef logic [strb_w-1:0]     strb_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [off_w-1:0]      offset_t;
    typedef logic [funct3_w-1:0]   funct3_t;
    // Raw instruction word
    typedef logic [xlen-1:0]       inst_t;

    //////////////////////////////////////////////////
    // RV32 encodings
    //////////////////////////////////////////////////

    // Major opcodes
    localparam logic [opc_w-1:0] opc_load  = 7'b0000011;
    localparam logic [opc_w-1:0] opc_store = 7'b0100011;

    // Access width, shared by loads and stores
    localparam funct3_t f3_b  = 3'd0;
    localparam funct3_t f3_h  = 3'd1;
    localparam funct3_t f3_w  = 3'd2;
    // Unsigned loads only
    localparam funct3_t f3_bu = 3'd4;
    localparam funct3_t f3_hu = 3'd5;

    // Field positions inside inst_t
    localparam int opc_lsb      = 0;
    localparam int rd_lsb       = 7;
    localparam int f3_lsb       = 12;
    localparam int rs1_lsb      = 15;
    localparam int rs2_lsb      = 20;
    // I-type immediate is one piece
    localparam int imm_i_lsb    = 20;
    // S-type immediate, upper piece first
    localparam int imm_s_hi_lsb = 25;
    localparam int imm_s_hi_w   = 7;
    localparam int imm_s_lo_lsb = 7;
    localparam int imm_s_lo_w   = 5;

    //////////////////////////////////////////////////
    // Control state
    //////////////////////////////////////////////////

    // Idle, load in flight, store in flight
    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_store
    } ctrl_state_t;

endpackage

//--- hw/memfy_req_if.sv
//////////////////////////////////////////////////
// Captured access handed from issue to AXI side
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface memfy_req_if;

    // Single cycle, instruction taken
    logic                  start;
    logic                  is_load;
    // Byte address and its low bits
    memfy_pkg::word_t      addr;
    memfy_pkg::offset_t    offset;
    memfy_pkg::funct3_t    funct3;
    memfy_pkg::reg_addr_t  rd;
    // Lane-aligned store payload
    memfy_pkg::word_t      wdata;
    memfy_pkg::strb_t      wstrb;
    // High while no access is in flight
    logic                  idle;

    modport issue (output start, is_load, addr, offset, funct3, rd, wdata, wstrb,
                   input  idle);

    modport ctrl  (input  start, is_load, addr, offset, funct3, wdata, wstrb,
                   output idle);

    // Load writeback only needs the format and target
    modport lane  (input  is_load, offset, funct3, rd, idle);

endinterface

//--- hw/memfy_issue.sv
//////////////////////////////////////////////////
// Load/store issue: decode, address and store lanes
//////////////////////////////////////////////////

`timescale 1ns/1ps

module memfy_issue (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic                  memfy_valid,
    input  memfy_pkg::inst_t      memfy_instbus,
    output memfy_pkg::reg_addr_t  memfy_rs1_addr,
    output memfy_pkg::reg_addr_t  memfy_rs2_addr,
    input  memfy_pkg::word_t      memfy_rs1_val,
    input  memfy_pkg::word_t      memfy_rs2_val,
    memfy_req_if.issue            req
);

    logic [memfy_pkg::opc_w-1:0]  opcode;
    logic [memfy_pkg::imm_w-1:0]  imm;
    logic                         is_load;
    logic                         is_store;
    memfy_pkg::funct3_t           funct3;
    memfy_pkg::word_t             addr;
    memfy_pkg::offset_t           offset;
    memfy_pkg::word_t             wdata;
    memfy_pkg::strb_t             wmask;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    assign opcode   = memfy_instbus[memfy_pkg::opc_lsb +: memfy_pkg::opc_w];
    assign funct3   = memfy_instbus[memfy_pkg::f3_lsb +: memfy_pkg::funct3_w];
    assign is_load  = (opcode == memfy_pkg::opc_load);
    assign is_store = (opcode == memfy_pkg::opc_store);

    // Register file reads go out straight from the bus
    assign memfy_rs1_addr = memfy_instbus[memfy_pkg::rs1_lsb +: memfy_pkg::reg_addr_w];
    assign memfy_rs2_addr = memfy_instbus[memfy_pkg::rs2_lsb +: memfy_pkg::reg_addr_w];

    // S-type splits the immediate around rd
    assign imm = is_store ?
        {memfy_instbus[memfy_pkg::imm_s_hi_lsb +: memfy_pkg::imm_s_hi_w],
         memfy_instbus[memfy_pkg::imm_s_lo_lsb +: memfy_pkg::imm_s_lo_w]} :
        memfy_instbus[memfy_pkg::imm_i_lsb +: memfy_pkg::imm_w];

    // Base plus sign-extended offset
    assign addr = memfy_rs1_val +
                  {{(memfy_pkg::xlen - memfy_pkg::imm_w){imm[memfy_pkg::imm_w-1]}}, imm};
    assign offset = addr[1:0];

    //////////////////////////////////////////////////
    // Store lanes
    //////////////////////////////////////////////////

    // Rotate rs2 left so byte 0 lands on the addressed lane
    always_comb begin
        case (offset)
            2'd1:    wdata = {memfy_rs2_val[23:0], memfy_rs2_val[31:24]};
            2'd2:    wdata = {memfy_rs2_val[15:0], memfy_rs2_val[31:16]};
            2'd3:    wdata = {memfy_rs2_val[7:0],  memfy_rs2_val[31:8]};
            default: wdata = memfy_rs2_val;
        endcase
    end

    // Width mask before it is moved to the offset
    always_comb begin
        case (funct3)
            memfy_pkg::f3_b: wmask = 4'b0001;
            memfy_pkg::f3_h: wmask = 4'b0011;
            default:         wmask = 4'b1111;
        endcase
    end

    //////////////////////////////////////////////////
    // Capture on acceptance
    //////////////////////////////////////////////////

    // Taken when the unit is idle, fields follow on the same edge
    assign req.start = memfy_valid & req.idle;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            req.is_load <= 1'b0;
        end else if (req.start) begin
            req.is_load <= is_load;
        end
    end

    // Payload held until the next instruction
    always_ff @(posedge aclk) begin
        if (req.start) begin
            req.addr   <= addr;
            req.offset <= offset;
            req.funct3 <= funct3;
            req.rd     <= memfy_instbus[memfy_pkg::rd_lsb +: memfy_pkg::reg_addr_w];
            req.wdata  <= wdata;
            // Natural alignment keeps the shifted mask inside the word
            req.wstrb  <= wmask << offset;
        end
    end

endmodule

//--- hw/memfy_axi_ctrl.sv
//////////////////////////////////////////////////
// AXI4-lite request control for one load or store
// Tracks channel handshakes and drives memfy_ready
//////////////////////////////////////////////////

`timescale 1ns/1ps

module memfy_axi_ctrl (
    input  logic              aclk,
    input  logic              aresetn,
    memfy_req_if.ctrl         req,
    output logic              memfy_ready,
    output logic              awvalid,
    output logic              wvalid,
    output logic              arvalid,
    output logic              rready,
    input  logic              awready,
    input  logic              wready,
    input  logic              arready,
    input  logic              rvalid,
    output memfy_pkg::word_t  awaddr,
    output memfy_pkg::word_t  araddr,
    output memfy_pkg::word_t  wdata,
    output memfy_pkg::strb_t  wstrb
);

    memfy_pkg::ctrl_state_t  state;
    // First cycle of an access, fields just captured
    logic                    launch;
    logic                    aw_done;
    logic                    w_done;
    logic                    ar_done;
    logic                    busy_load;
    logic                    busy_store;
    logic                    aw_hs;
    logic                    w_hs;
    logic                    ar_hs;
    logic                    r_hs;
    logic                    store_done;

    //////////////////////////////////////////////////
    // Channel requests
    //////////////////////////////////////////////////

    // Access kind is known from launch onwards
    assign busy_load  = (launch & req.is_load) | (state == memfy_pkg::st_load);
    assign busy_store = (launch & ~req.is_load) | (state == memfy_pkg::st_store);

    // Each valid drops once its handshake is recorded
    assign awvalid = busy_store & ~aw_done;
    assign wvalid  = busy_store & ~w_done;
    assign arvalid = busy_load & ~ar_done;
    // Read data accepted for the whole load
    assign rready  = busy_load;

    // Address and data come from the captured access
    assign awaddr = req.addr;
    assign araddr = req.addr;
    assign wdata  = req.wdata;
    assign wstrb  = req.wstrb;

    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;
    assign ar_hs = arvalid & arready;
    // R only counts once AR went through, this cycle or before
    assign r_hs  = rvalid & rready & (ar_done | ar_hs);

    // B channel is not waited for
    assign store_done = busy_store & (aw_done | aw_hs) & (w_done | w_hs);

    assign req.idle = memfy_ready;

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= memfy_pkg::st_idle;
            launch      <= 1'b0;
            memfy_ready <= 1'b0;
            aw_done     <= 1'b0;
            w_done      <= 1'b0;
            ar_done     <= 1'b0;
        end else begin
            launch <= req.start;
            if (req.start) begin
                // Instruction taken, busy from now on
                memfy_ready <= 1'b0;
                aw_done     <= 1'b0;
                w_done      <= 1'b0;
                ar_done     <= 1'b0;
            end else if (store_done || r_hs) begin
                // Access finished, ready again next cycle
                state       <= memfy_pkg::st_idle;
                memfy_ready <= 1'b1;
            end else begin
                if (launch) begin
                    state <= req.is_load ? memfy_pkg::st_load : memfy_pkg::st_store;
                end
                if (aw_hs) aw_done <= 1'b1;
                if (w_hs)  w_done  <= 1'b1;
                if (ar_hs) ar_done <= 1'b1;
                // Out of reset nothing is pending
                if (state == memfy_pkg::st_idle && !launch) begin
                    memfy_ready <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/memfy_load_lane.sv
//////////////////////////////////////////////////
// Load data alignment, extension and rd writeback
//////////////////////////////////////////////////

`timescale 1ns/1ps

module memfy_load_lane (
    input  logic                  aclk,
    input  logic                  aresetn,
    memfy_req_if.lane             req,
    input  logic                  rvalid,
    input  logic                  rready,
    input  memfy_pkg::word_t      rdata,
    output logic                  memfy_rd_wr,
    output memfy_pkg::reg_addr_t  memfy_rd_addr,
    output memfy_pkg::word_t      memfy_rd_val
);

    memfy_pkg::word_t  aligned;
    memfy_pkg::word_t  extended;
    logic              r_load;

    // Bring the addressed byte down to bit 0
    always_comb begin
        case (req.offset)
            2'd1:    aligned = {rdata[7:0],  rdata[31:8]};
            2'd2:    aligned = {rdata[15:0], rdata[31:16]};
            2'd3:    aligned = {rdata[23:0], rdata[31:24]};
            default: aligned = rdata;
        endcase
    end

    // Keep the access width, then extend
    always_comb begin
        case (req.funct3)
            memfy_pkg::f3_b:  extended = {{24{aligned[7]}}, aligned[7:0]};
            memfy_pkg::f3_bu: extended = {24'd0, aligned[7:0]};
            memfy_pkg::f3_h:  extended = {{16{aligned[15]}}, aligned[15:0]};
            memfy_pkg::f3_hu: extended = {16'd0, aligned[15:0]};
            default:          extended = aligned;
        endcase
    end

    // R handshake while a load is in flight
    assign r_load = req.is_load & ~req.idle & rvalid & rready;

    //////////////////////////////////////////////////
    // Writeback
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            memfy_rd_wr <= 1'b0;
        end else begin
            // One pulse, the unit goes idle on the same edge
            memfy_rd_wr <= r_load;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_load) begin
            memfy_rd_val  <= extended;
            memfy_rd_addr <= req.rd;
        end
    end

endmodule

//--- hw/memfy.sv
//////////////////////////////////////////////////
// RV32 load/store unit top level
// Instruction handshake in, AXI4-lite access out
//////////////////////////////////////////////////

`timescale 1ns/1ps

module memfy (
    input  logic                  aclk,
    input  logic                  aresetn,
    // Instruction from the core
    input  logic                  memfy_valid,
    output logic                  memfy_ready,
    input  memfy_pkg::inst_t      memfy_instbus,
    // Register file reads
    output memfy_pkg::reg_addr_t  memfy_rs1_addr,
    input  memfy_pkg::word_t      memfy_rs1_val,
    output memfy_pkg::reg_addr_t  memfy_rs2_addr,
    input  memfy_pkg::word_t      memfy_rs2_val,
    // Register file write
    output logic                  memfy_rd_wr,
    output memfy_pkg::reg_addr_t  memfy_rd_addr,
    output memfy_pkg::word_t      memfy_rd_val,
    // AXI4-lite write address and data
    output logic                  awvalid,
    input  logic                  awready,
    output memfy_pkg::word_t      awaddr,
    output logic                  wvalid,
    input  logic                  wready,
    output memfy_pkg::word_t      wdata,
    output memfy_pkg::strb_t      wstrb,
    // AXI4-lite read address and data
    output logic                  arvalid,
    input  logic                  arready,
    output memfy_pkg::word_t      araddr,
    input  logic                  rvalid,
    output logic                  rready,
    input  memfy_pkg::word_t      rdata
);

    // Captured access shared by the three blocks
    memfy_req_if i_req ();

    // Decode and capture
    memfy_issue i_issue (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .memfy_valid    (memfy_valid),
        .memfy_instbus  (memfy_instbus),
        .memfy_rs1_addr (memfy_rs1_addr),
        .memfy_rs2_addr (memfy_rs2_addr),
        .memfy_rs1_val  (memfy_rs1_val),
        .memfy_rs2_val  (memfy_rs2_val),
        .req            (i_req.issue)
    );

    // Bus requests and completion
    memfy_axi_ctrl i_axi_ctrl (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .req         (i_req.ctrl),
        .memfy_ready (memfy_ready),
        .awvalid     (awvalid),
        .wvalid      (wvalid),
        .arvalid     (arvalid),
        .rready      (rready),
        .awready     (awready),
        .wready      (wready),
        .arready     (arready),
        .rvalid      (rvalid),
        .awaddr      (awaddr),
        .araddr      (araddr),
        .wdata       (wdata),
        .wstrb       (wstrb)
    );

    // Load result into rd
    memfy_load_lane i_load_lane (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .req           (i_req.lane),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .memfy_rd_wr   (memfy_rd_wr),
        .memfy_rd_addr (memfy_rd_addr),
        .memfy_rd_val  (memfy_rd_val)
    );

endmodule

//--- verif/memfy_assertions.sv
//////////////////////////////////////////////////
// Protocol checks for the load/store unit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module memfy_assertions (
    input logic aclk,
    input logic aresetn,
    input logic memfy_ready,
    input logic memfy_rd_wr,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic arvalid,
    input logic arready
);

    // Failed assertion count
    int failures = 0;

    // Each request holds until the memory takes it
    a_aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        awvalid && !awready |=> awvalid)
        else begin
            failures++;
            $error("awvalid dropped before awready");
        end

    a_w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        wvalid && !wready |=> wvalid)
        else begin
            failures++;
            $error("wvalid dropped before wready");
        end

    a_ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        arvalid && !arready |=> arvalid)
        else begin
            failures++;
            $error("arvalid dropped before arready");
        end

    // Unit is busy while any request is out
    a_busy: assert property (@(posedge aclk) disable iff (!aresetn)
        (awvalid || wvalid || arvalid) |-> !memfy_ready)
        else begin
            failures++;
            $error("memfy_ready high with a request outstanding");
        end

    // Register write is a single cycle pulse
    a_rd_wr_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
        memfy_rd_wr |=> !memfy_rd_wr)
        else begin
            failures++;
            $error("memfy_rd_wr held for more than one cycle");
        end

endmodule

//--- verif/memfy_tb.sv
//////////////////////////////////////////////////
// Directed testbench for the load/store unit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module memfy_tb;

    localparam int drv = 1;
    // About 50 accesses of at most 20 cycles each plus reset, with wide margin
    localparam int max_cycles = 4000;
    localparam memfy_pkg::reg_addr_t rs1_idx = 5'd11;
    localparam memfy_pkg::reg_addr_t rs2_idx = 5'd12;

    logic aclk, aresetn, memfy_valid, memfy_ready, memfy_rd_wr;
    logic awvalid, awready, wvalid, wready, arvalid, arready, rvalid, rready;
    memfy_pkg::inst_t     memfy_instbus;
    memfy_pkg::reg_addr_t memfy_rs1_addr, memfy_rs2_addr, memfy_rd_addr;
    memfy_pkg::word_t     memfy_rs1_val, memfy_rs2_val, memfy_rd_val;
    memfy_pkg::word_t     awaddr, araddr, wdata, rdata;
    memfy_pkg::strb_t     wstrb;

    // Memory model state and what it saw on each channel
    memfy_pkg::word_t     mem [256];
    memfy_pkg::word_t     last_awaddr, last_wdata, last_araddr, last_rd_val;
    memfy_pkg::strb_t     last_wstrb;
    memfy_pkg::reg_addr_t last_rd_addr;
    int aw_cnt = 0, w_cnt = 0, ar_cnt = 0, r_cnt = 0, wr_cnt = 0;
    int aw_wait = 0, w_wait = 0, ar_wait = 0, r_wait = 0;
    logic random_delays = 1'b0;
    int errors = 0, checks = 0, cycles = 0;

    memfy i_memfy (.*);

    bind memfy memfy_assertions i_assertions (
        .aclk (aclk), .aresetn (aresetn), .memfy_ready (memfy_ready),
        .memfy_rd_wr (memfy_rd_wr), .awvalid (awvalid), .awready (awready),
        .wvalid (wvalid), .wready (wready), .arvalid (arvalid), .arready (arready)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    initial begin : watchdog
        while (cycles < max_cycles) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("Testbench failed");
        $finish;
    end

    function automatic int next_delay();
        return random_delays ? int'($urandom % 6) : 0;
    endfunction

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    // Handshakes sampled mid cycle, readies and read data driven after the edge
    initial begin : memory_model
        logic aw_fire, w_fire, ar_fire, r_fire, aw_got, w_got, r_pending;
        aw_got = 1'b0;
        w_got = 1'b0;
        r_pending = 1'b0;
        forever begin
            @(negedge aclk);
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            ar_fire = arvalid && arready;
            r_fire  = rvalid && rready;
            if (aw_fire) begin
                aw_cnt++;
                aw_got = 1'b1;
                last_awaddr = awaddr;
            end
            if (w_fire) begin
                w_cnt++;
                w_got = 1'b1;
                last_wdata = wdata;
                last_wstrb = wstrb;
            end
            // Write lands once address and data are both in
            if (aw_got && w_got) begin
                for (int b = 0; b < 4; b++) begin
                    if (last_wstrb[b]) mem[last_awaddr[9:2]][8*b +: 8] = last_wdata[8*b +: 8];
                end
                aw_got = 1'b0;
                w_got = 1'b0;
            end
            if (ar_fire) begin
                ar_cnt++;
                last_araddr = araddr;
            end
            if (r_fire) r_cnt++;
            if (memfy_rd_wr) begin
                wr_cnt++;
                last_rd_val = memfy_rd_val;
                last_rd_addr = memfy_rd_addr;
            end
            @(posedge aclk);
            #drv;
            if (aw_fire) begin
                awready = 1'b0;
                aw_wait = next_delay();
            end else if (awvalid && !awready) begin
                if (aw_wait == 0) awready = 1'b1;
                else aw_wait--;
            end
            if (w_fire) begin
                wready = 1'b0;
                w_wait = next_delay();
            end else if (wvalid && !wready) begin
                if (w_wait == 0) wready = 1'b1;
                else w_wait--;
            end
            if (ar_fire) begin
                arready = 1'b0;
                ar_wait = next_delay();
                r_pending = 1'b1;
                r_wait = next_delay();
            end else if (arvalid && !arready) begin
                if (ar_wait == 0) arready = 1'b1;
                else ar_wait--;
            end
            // Read data only after the address was taken
            if (r_fire) begin
                rvalid = 1'b0;
            end else if (r_pending && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata = mem[last_araddr[9:2]];
                    r_pending = 1'b0;
                end else begin
                    r_wait--;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic expect_equal(input string name, input memfy_pkg::word_t got,
                                input memfy_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    function automatic memfy_pkg::inst_t load_inst(input memfy_pkg::funct3_t f3,
                                                   input memfy_pkg::reg_addr_t rd,
                                                   input logic [11:0] imm);
        return {imm, rs1_idx, f3, rd, memfy_pkg::opc_load};
    endfunction

    function automatic memfy_pkg::inst_t store_inst(input memfy_pkg::funct3_t f3,
                                                    input logic [11:0] imm);
        return {imm[11:5], rs2_idx, rs1_idx, f3, imm[4:0], memfy_pkg::opc_store};
    endfunction

    // One instruction from handshake to completion, with channel counts
    task automatic run_access(input memfy_pkg::inst_t inst, input logic is_load,
                              input memfy_pkg::word_t rs1v, input memfy_pkg::word_t rs2v);
        int aw0, w0, ar0, r0, wr0;
        aw0 = aw_cnt;
        w0 = w_cnt;
        ar0 = ar_cnt;
        r0 = r_cnt;
        wr0 = wr_cnt;
        while (!memfy_ready) begin
            @(posedge aclk);
            #drv;
        end
        memfy_valid = 1'b1;
        memfy_instbus = inst;
        memfy_rs1_val = rs1v;
        memfy_rs2_val = rs2v;
        @(negedge aclk);
        expect_equal("memfy_rs1_addr", memfy_rs1_addr, rs1_idx);
        if (!is_load) expect_equal("memfy_rs2_addr", memfy_rs2_addr, rs2_idx);
        @(posedge aclk);
        #drv;
        memfy_valid = 1'b0;
        // Ready falls on the edge that takes the instruction
        expect_equal("memfy_ready", memfy_ready, 1'b0);
        while (!memfy_ready) begin
            @(posedge aclk);
            #drv;
        end
        // Completion must follow exactly one handshake per used channel
        expect_equal("AW handshakes", aw_cnt - aw0, is_load ? 0 : 1);
        expect_equal("W handshakes", w_cnt - w0, is_load ? 0 : 1);
        expect_equal("AR handshakes", ar_cnt - ar0, is_load ? 1 : 0);
        expect_equal("R handshakes", r_cnt - r0, is_load ? 1 : 0);
        @(posedge aclk);
        #drv;
        expect_equal("memfy_rd_wr pulses", wr_cnt - wr0, is_load ? 1 : 0);
    endtask

    task automatic do_store(input memfy_pkg::funct3_t f3, input memfy_pkg::word_t base,
                            input logic [11:0] imm, input memfy_pkg::word_t data);
        memfy_pkg::word_t addr, exp_word, exp_data;
        memfy_pkg::strb_t exp_strb;
        int off, nbytes;
        addr = base + {{20{imm[11]}}, imm};
        off = addr[1:0];
        nbytes = (f3 == memfy_pkg::f3_b) ? 1 : ((f3 == memfy_pkg::f3_h) ? 2 : 4);
        exp_word = mem[addr[9:2]];
        exp_strb = '0;
        exp_data = (off == 0) ? data : ((data << (8 * off)) | (data >> (32 - 8 * off)));
        for (int i = 0; i < nbytes; i++) begin
            exp_word[8*(off+i) +: 8] = data[8*i +: 8];
            exp_strb[off+i] = 1'b1;
        end
        run_access(store_inst(f3, imm), 1'b0, base, data);
        expect_equal("awaddr", last_awaddr, addr);
        expect_equal("wstrb", last_wstrb, exp_strb);
        expect_equal("wdata", last_wdata, exp_data);
        expect_equal("memory word", mem[addr[9:2]], exp_word);
    endtask

    task automatic do_load(input memfy_pkg::funct3_t f3, input memfy_pkg::reg_addr_t rd,
                           input memfy_pkg::word_t base, input logic [11:0] imm);
        memfy_pkg::word_t addr, v, exp;
        byte sb;
        shortint sh;
        addr = base + {{20{imm[11]}}, imm};
        v = mem[addr[9:2]] >> (8 * addr[1:0]);
        sb = v[7:0];
        sh = v[15:0];
        // Signed types carry the sign into the upper bits
        case (f3)
            memfy_pkg::f3_b:  exp = sb;
            memfy_pkg::f3_bu: exp = v[7:0];
            memfy_pkg::f3_h:  exp = sh;
            memfy_pkg::f3_hu: exp = v[15:0];
            default:          exp = v;
        endcase
        run_access(load_inst(f3, rd, imm), 1'b1, base, 32'h0);
        expect_equal("araddr", last_araddr, addr);
        expect_equal("memfy_rd_val", last_rd_val, exp);
        expect_equal("memfy_rd_addr", last_rd_addr, rd);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        aresetn = 1'b0;
        repeat (16) begin
            @(negedge aclk);
            expect_equal("{memfy_ready,awvalid,wvalid,arvalid,rready,memfy_rd_wr}",
                         {memfy_ready, awvalid, wvalid, arvalid, rready, memfy_rd_wr}, 0);
        end
        @(posedge aclk);
        #drv;
        aresetn = 1'b1;
        repeat (2) begin
            @(posedge aclk);
            #drv;
        end
        expect_equal("memfy_ready", memfy_ready, 1'b1);
    endtask

    task automatic test_word();
        do_store(memfy_pkg::f3_w, 32'h100, 12'h010, 32'hdeadbeef);
        do_load(memfy_pkg::f3_w, 5'd5, 32'h100, 12'h010);
        expect_equal("memfy_rd_val", last_rd_val, 32'hdeadbeef);
        // Negative offset below the base
        do_store(memfy_pkg::f3_w, 32'h200, 12'hff8, 32'h01234567);
        do_load(memfy_pkg::f3_w, 5'd17, 32'h200, 12'hff8);
        expect_equal("memfy_rd_val", last_rd_val, 32'h01234567);
    endtask

    task automatic test_store_lanes();
        for (int off = 0; off < 4; off++) begin
            do_store(memfy_pkg::f3_b, 32'h40, 12'(off), 32'ha0b1c2d0 + off);
        end
        do_store(memfy_pkg::f3_h, 32'h60, 12'h000, 32'h55667788);
        do_store(memfy_pkg::f3_h, 32'h60, 12'h002, 32'h99aabbcc);
    endtask

    task automatic test_load_ext();
        // Top bit set in every byte lane
        mem[8'h20] = 32'h9cb48ef1;
        for (int off = 0; off < 4; off++) begin
            do_load(memfy_pkg::f3_b, 5'(off + 1), 32'h80, 12'(off));
            do_load(memfy_pkg::f3_bu, 5'(off + 8), 32'h80, 12'(off));
        end
        for (int off = 0; off < 4; off += 2) begin
            do_load(memfy_pkg::f3_h, 5'(off + 20), 32'h80, 12'(off));
            do_load(memfy_pkg::f3_hu, 5'(off + 25), 32'h80, 12'(off));
        end
    endtask

    task automatic test_backpressure();
        memfy_pkg::funct3_t f3;
        memfy_pkg::word_t base;
        memfy_pkg::reg_addr_t rd;
        logic [11:0] imm;
        logic is_load;
        random_delays = 1'b1;
        for (int n = 0; n < 24; n++) begin
            is_load = $urandom % 2;
            f3 = memfy_pkg::funct3_t'($urandom % 3);
            base = ($urandom % 256) << 2;
            rd = $urandom % 32;
            // Natural alignment for the chosen width
            case (f3)
                memfy_pkg::f3_b: imm = $urandom % 4;
                memfy_pkg::f3_h: imm = ($urandom % 2) * 2;
                default:         imm = 12'h000;
            endcase
            if (is_load) begin
                if (f3 != memfy_pkg::f3_w && ($urandom % 2) == 1) f3[2] = 1'b1;
                do_load(f3, rd, base, imm);
            end else begin
                do_store(f3, base, imm, $urandom);
            end
        end
        random_delays = 1'b0;
    endtask

    initial begin : main
        void'($urandom(96543));
        aresetn = 1'b0;
        memfy_valid = 1'b0;
        memfy_instbus = '0;
        memfy_rs1_val = '0;
        memfy_rs2_val = '0;
        awready = 1'b0;
        wready = 1'b0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        // Fill pattern tied to every index bit
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i) ^ 8'hc3, 8'h5a, ~8'(i), 8'(i)};
        end
        test_reset();
        test_word();
        test_store_lanes();
        test_load_ext();
        test_backpressure();
        errors += i_memfy.i_assertions.failures;
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
hw/memfy_pkg.sv
hw/memfy_req_if.sv
hw/memfy_issue.sv
hw/memfy_axi_ctrl.sv
hw/memfy_load_lane.sv
hw/memfy.sv
verif/memfy_assertions.sv
verif/memfy_tb.sv
